/* frv_defs.svh */
// Shared widths, reset PC and RISC-V encoding fields for the integer pipeline.
// Include wherever a width or an opcode field is needed.

`ifndef FRV_DEFS_SVH
`define FRV_DEFS_SVH

`define FRV_XLEN            32               // Data word width
`define FRV_REG_AW          5                // Register index width
`define FRV_PC_RESET_VALUE  32'h8000_0000    // PC of first accepted instruction
`define FRV_PC_STEP         32'd4            // PC increment per instruction

// ------------------------------------------------------------------------
// Major opcodes and function fields

`define FRV_OPC_OP          7'b0110011       // Register-register ALU
`define FRV_OPC_OP_IMM      7'b0010011       // Register-immediate ALU

`define FRV_F3_ADD          3'b000           // ADD, SUB, ADDI
`define FRV_F3_SLL          3'b001
`define FRV_F3_XOR          3'b100
`define FRV_F3_SRL          3'b101
`define FRV_F3_OR           3'b110
`define FRV_F3_AND          3'b111

`define FRV_F7_ALT          7'b0100000       // Selects SUB over ADD

`endif

/* frv_pkg.sv */
// Types shared by every pipeline stage.
// Refer to them by scoped names, e.g. frv_pkg::frv_word_t.
`default_nettype none

`include "frv_defs.svh"

package frv_pkg;

    typedef logic [`FRV_XLEN-1:0]   frv_word_t;     // One data word
    typedef logic [`FRV_REG_AW-1:0] frv_reg_addr_t; // Register index

    // Micro-ops carried from decode to execute
    typedef enum logic [3:0] {
        UOP_ADD,
        UOP_SUB,
        UOP_AND,
        UOP_OR,
        UOP_XOR,
        UOP_SLL,
        UOP_SRL,
        UOP_ADDI,
        UOP_NOP                                     // Unsupported encoding
    } frv_uop_e;

endpackage

`default_nettype wire

/* frv_stage_if.sv */
// Stage-to-stage links of the pipeline, all on the valid/busy handshake.
// A transfer happens on a clock edge with valid high and busy low.
`timescale 1ns/1ps
`default_nettype none

// Fetch buffer to decode
interface frv_fetch_if;
    logic               valid;
    logic               busy;
    frv_pkg::frv_word_t pc;
    frv_pkg::frv_word_t instr;

    modport sender   (output valid, pc, instr, input busy);
    modport receiver (input valid, pc, instr, output busy);
endinterface

// Decode to execute
interface frv_issue_if;
    logic                   valid;
    logic                   busy;
    frv_pkg::frv_uop_e      uop;
    frv_pkg::frv_word_t     opr_a;
    frv_pkg::frv_word_t     opr_b;
    frv_pkg::frv_reg_addr_t rd;
    frv_pkg::frv_word_t     pc;
    frv_pkg::frv_word_t     instr;

    modport sender   (output valid, uop, opr_a, opr_b, rd, pc, instr, input busy);
    modport receiver (input valid, uop, opr_a, opr_b, rd, pc, instr, output busy);
endinterface

// Execute to writeback
interface frv_result_if;
    logic                   valid;
    logic                   busy;
    frv_pkg::frv_reg_addr_t rd;
    frv_pkg::frv_word_t     wdata;
    frv_pkg::frv_word_t     pc;
    frv_pkg::frv_word_t     instr;

    modport sender   (output valid, rd, wdata, pc, instr, input busy);
    modport receiver (input valid, rd, wdata, pc, instr, output busy);
endinterface

`default_nettype wire

/* frv_fetch_buffer.sv */
// Input side of the pipeline. Takes instruction words off the valid/busy
// stream, tags each one with its PC and holds it until decode takes it.
`timescale 1ns/1ps
`default_nettype none

`include "frv_defs.svh"

module frv_fetch_buffer (
    input  logic               g_clk,
    input  logic               arst_n,
    input  logic               in_valid,
    input  frv_pkg::frv_word_t in_instr,
    output logic               in_busy,
    frv_fetch_if.sender        fetch
);

    frv_pkg::frv_word_t pc_next;                    // PC for the next accepted word
    logic               take;                       // Word accepted this cycle

    assign in_busy = fetch.valid && fetch.busy;     // Full and decode stalled
    assign take    = in_valid && !in_busy;

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch.valid <= 1'b0;
            pc_next     <= `FRV_PC_RESET_VALUE;
        end else if (!in_busy) begin
            fetch.valid <= in_valid;                // Drains when nothing arrives
            if (in_valid) begin
                pc_next <= pc_next + `FRV_PC_STEP;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (take) begin
            fetch.pc    <= pc_next;
            fetch.instr <= in_instr;
        end
    end

endmodule

`default_nettype wire

/* frv_decode.sv */
// Decode stage. Maps an instruction word onto a micro-op, collects the
// forwarded source operands and loads the issue register for execute.
// Unsupported encodings travel on as NOPs with no destination.
`timescale 1ns/1ps
`default_nettype none

`include "frv_defs.svh"

module frv_decode (
    input  logic                   g_clk,
    input  logic                   arst_n,
    frv_fetch_if.receiver          fetch,
    frv_issue_if.sender            issue,
    output frv_pkg::frv_reg_addr_t rs1_addr,
    output frv_pkg::frv_reg_addr_t rs2_addr,
    input  frv_pkg::frv_word_t     rs1_data,
    input  frv_pkg::frv_word_t     rs2_data
);

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    frv_pkg::frv_uop_e  uop;
    frv_pkg::frv_word_t imm_i;                      // Sign extended I-type immediate
    logic               take;

    assign opcode   = fetch.instr[6:0];
    assign funct3   = fetch.instr[14:12];
    assign funct7   = fetch.instr[31:25];
    assign rs1_addr = fetch.instr[19:15];
    assign rs2_addr = fetch.instr[24:20];
    assign imm_i    = {{(`FRV_XLEN-12){fetch.instr[31]}}, fetch.instr[31:20]};

    // ------------------------------------------------------------------------
    // Opcode match

    always_comb begin
        uop = frv_pkg::UOP_NOP;
        if (opcode == `FRV_OPC_OP_IMM && funct3 == `FRV_F3_ADD) begin
            uop = frv_pkg::UOP_ADDI;
        end else if (opcode == `FRV_OPC_OP && funct7 == `FRV_F7_ALT) begin
            if (funct3 == `FRV_F3_ADD) begin
                uop = frv_pkg::UOP_SUB;             // SRA and friends stay NOP
            end
        end else if (opcode == `FRV_OPC_OP && funct7 == 7'd0) begin
            case (funct3)
                `FRV_F3_ADD: uop = frv_pkg::UOP_ADD;
                `FRV_F3_SLL: uop = frv_pkg::UOP_SLL;
                `FRV_F3_XOR: uop = frv_pkg::UOP_XOR;
                `FRV_F3_SRL: uop = frv_pkg::UOP_SRL;
                `FRV_F3_OR:  uop = frv_pkg::UOP_OR;
                `FRV_F3_AND: uop = frv_pkg::UOP_AND;
                default:     uop = frv_pkg::UOP_NOP; // SLT, SLTU
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Issue register

    assign fetch.busy = issue.valid && issue.busy;  // Hold while execute stalls
    assign take       = fetch.valid && !fetch.busy;

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            issue.valid <= 1'b0;
        end else if (!fetch.busy) begin
            issue.valid <= fetch.valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (take) begin
            issue.uop   <= uop;
            issue.opr_a <= rs1_data;
            issue.opr_b <= (uop == frv_pkg::UOP_ADDI) ? imm_i : rs2_data;
            issue.rd    <= (uop == frv_pkg::UOP_NOP) ? '0 : fetch.instr[11:7];
            issue.pc    <= fetch.pc;
            issue.instr <= fetch.instr;
        end
    end

endmodule

`default_nettype wire

/* frv_forward.sv */
// Operand forwarding for decode. Each source takes the youngest in-flight
// result with a matching non-zero destination, else the register file value.
`timescale 1ns/1ps
`default_nettype none

module frv_forward (
    input  frv_pkg::frv_reg_addr_t rs1_addr,
    input  frv_pkg::frv_reg_addr_t rs2_addr,
    input  frv_pkg::frv_word_t     rs1_gpr,
    input  frv_pkg::frv_word_t     rs2_gpr,
    input  logic                   ex_valid,
    input  frv_pkg::frv_reg_addr_t ex_rd,
    input  frv_pkg::frv_word_t     ex_wdata,
    input  logic                   wb_valid,
    input  frv_pkg::frv_reg_addr_t wb_rd,
    input  frv_pkg::frv_word_t     wb_wdata,
    output frv_pkg::frv_word_t     rs1_data,
    output frv_pkg::frv_word_t     rs2_data
);

    logic rs1_nz;                                   // Source is not x0
    logic rs2_nz;

    assign rs1_nz = (rs1_addr != '0);
    assign rs2_nz = (rs2_addr != '0);

    // Nearest stage wins and x0 never forwards
    assign rs1_data = (rs1_nz && ex_valid && ex_rd == rs1_addr) ? ex_wdata :
                      (rs1_nz && wb_valid && wb_rd == rs1_addr) ? wb_wdata : rs1_gpr;
    assign rs2_data = (rs2_nz && ex_valid && ex_rd == rs2_addr) ? ex_wdata :
                      (rs2_nz && wb_valid && wb_rd == rs2_addr) ? wb_wdata : rs2_gpr;

endmodule

`default_nettype wire

/* frv_gprs.sv */
// General purpose register file. Two asynchronous read ports, one write
// port; x0 always reads zero and ignores writes.
`timescale 1ns/1ps
`default_nettype none

`include "frv_defs.svh"

module frv_gprs (
    input  logic                   g_clk,
    input  logic                   arst_n,
    input  frv_pkg::frv_reg_addr_t rs1_addr,
    input  frv_pkg::frv_reg_addr_t rs2_addr,
    output frv_pkg::frv_word_t     rs1_data,
    output frv_pkg::frv_word_t     rs2_data,
    input  logic                   gpr_wen,
    input  frv_pkg::frv_reg_addr_t gpr_rd,
    input  frv_pkg::frv_word_t     gpr_wdata
);

    frv_pkg::frv_word_t regs [1:(1<<`FRV_REG_AW)-1]; // No storage for x0

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < (1 << `FRV_REG_AW); i++) begin
                regs[i] <= '0;
            end
        end else if (gpr_wen && gpr_rd != '0) begin
            regs[gpr_rd] <= gpr_wdata;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* frv_execute.sv */
// Execute stage. Runs the ALU on the issued micro-op, exports the result
// for forwarding and loads the result register for writeback.
`timescale 1ns/1ps
`default_nettype none

module frv_execute (
    input  logic                   g_clk,
    input  logic                   arst_n,
    frv_issue_if.receiver          issue,
    frv_result_if.sender           result,
    output logic                   ex_valid,
    output frv_pkg::frv_reg_addr_t ex_rd,
    output frv_pkg::frv_word_t     ex_wdata
);

    frv_pkg::frv_word_t alu;
    logic               take;

    // ------------------------------------------------------------------------
    // ALU

    always_comb begin
        case (issue.uop)
            frv_pkg::UOP_ADD,
            frv_pkg::UOP_ADDI: alu = issue.opr_a + issue.opr_b;   // Wraps
            frv_pkg::UOP_SUB:  alu = issue.opr_a - issue.opr_b;
            frv_pkg::UOP_AND:  alu = issue.opr_a & issue.opr_b;
            frv_pkg::UOP_OR:   alu = issue.opr_a | issue.opr_b;
            frv_pkg::UOP_XOR:  alu = issue.opr_a ^ issue.opr_b;
            frv_pkg::UOP_SLL:  alu = issue.opr_a << issue.opr_b[4:0];
            frv_pkg::UOP_SRL:  alu = issue.opr_a >> issue.opr_b[4:0]; // Logical
            default:           alu = '0;                              // NOP
        endcase
    end

    assign ex_valid = issue.valid;                  // Youngest forward source
    assign ex_rd    = issue.rd;
    assign ex_wdata = alu;

    // ------------------------------------------------------------------------
    // Result register

    assign issue.busy = result.valid && result.busy;
    assign take       = issue.valid && !issue.busy;

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            result.valid <= 1'b0;
        end else if (!issue.busy) begin
            result.valid <= issue.valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (take) begin
            result.rd    <= issue.rd;
            result.wdata <= alu;
            result.pc    <= issue.pc;
            result.instr <= issue.instr;
        end
    end

endmodule

`default_nettype wire

/* frv_writeback.sv */
// Writeback stage. Commits each result to the register file as it moves
// into the trace register, then presents it until the consumer takes it.
// Instructions still waiting in the result register are forwarded from here.
`timescale 1ns/1ps
`default_nettype none

module frv_writeback (
    input  logic                   g_clk,
    input  logic                   arst_n,
    frv_result_if.receiver         result,
    input  logic                   trs_busy,
    output logic                   trs_valid,
    output frv_pkg::frv_word_t     trs_pc,
    output frv_pkg::frv_word_t     trs_instr,
    output frv_pkg::frv_reg_addr_t trs_rd,
    output frv_pkg::frv_word_t     trs_wdata,
    output logic                   wb_valid,
    output frv_pkg::frv_reg_addr_t wb_rd,
    output frv_pkg::frv_word_t     wb_wdata,
    output logic                   gpr_wen,
    output frv_pkg::frv_reg_addr_t gpr_rd,
    output frv_pkg::frv_word_t     gpr_wdata
);

    logic take;

    assign result.busy = trs_valid && trs_busy;     // Trace consumer stall
    assign take        = result.valid && !result.busy;

    // Not yet in the register file, so offered for forwarding
    assign wb_valid  = result.valid;
    assign wb_rd     = result.rd;
    assign wb_wdata  = result.wdata;

    assign gpr_wen   = take;                        // One write per instruction
    assign gpr_rd    = result.rd;
    assign gpr_wdata = result.wdata;

    // ------------------------------------------------------------------------
    // Trace register

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            trs_valid <= 1'b0;
        end else if (!result.busy) begin
            trs_valid <= result.valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (take) begin
            trs_pc    <= result.pc;
            trs_instr <= result.instr;
            trs_rd    <= result.rd;
            trs_wdata <= result.wdata;
        end
    end

endmodule

`default_nettype wire

/* frv_core_top.sv */
// Top level of the in-order integer pipeline. Instructions enter on the
// in_* stream and every retired instruction leaves on the trs_* trace port.
`timescale 1ns/1ps
`default_nettype none

module frv_core_top (
    input  logic                   g_clk,
    input  logic                   arst_n,
    input  logic                   in_valid,
    input  frv_pkg::frv_word_t     in_instr,
    output logic                   in_busy,
    output logic                   trs_valid,
    output frv_pkg::frv_word_t     trs_pc,
    output frv_pkg::frv_word_t     trs_instr,
    output frv_pkg::frv_reg_addr_t trs_rd,
    output frv_pkg::frv_word_t     trs_wdata,
    input  logic                   trs_busy
);

    frv_pkg::frv_reg_addr_t rs1_addr;               // Decode source addresses
    frv_pkg::frv_reg_addr_t rs2_addr;
    frv_pkg::frv_word_t     rs1_gpr;                // Raw register file data
    frv_pkg::frv_word_t     rs2_gpr;
    frv_pkg::frv_word_t     rs1_fwd;                // Forwarded operands
    frv_pkg::frv_word_t     rs2_fwd;
    logic                   ex_valid;
    frv_pkg::frv_reg_addr_t ex_rd;
    frv_pkg::frv_word_t     ex_wdata;
    logic                   wb_valid;
    frv_pkg::frv_reg_addr_t wb_rd;
    frv_pkg::frv_word_t     wb_wdata;
    logic                   gpr_wen;
    frv_pkg::frv_reg_addr_t gpr_rd;
    frv_pkg::frv_word_t     gpr_wdata;

    frv_fetch_if  fetch_bus  ();
    frv_issue_if  issue_bus  ();
    frv_result_if result_bus ();

    // ------------------------------------------------------------------------
    // Stages

    frv_fetch_buffer i_fetch (
        .g_clk    (g_clk    ),
        .arst_n   (arst_n   ),
        .in_valid (in_valid ),
        .in_instr (in_instr ),
        .in_busy  (in_busy  ),
        .fetch    (fetch_bus)
    );

    frv_decode i_decode (
        .g_clk    (g_clk    ),
        .arst_n   (arst_n   ),
        .fetch    (fetch_bus),
        .issue    (issue_bus),
        .rs1_addr (rs1_addr ),
        .rs2_addr (rs2_addr ),
        .rs1_data (rs1_fwd  ),
        .rs2_data (rs2_fwd  )
    );

    frv_forward i_forward (
        .rs1_addr (rs1_addr ),
        .rs2_addr (rs2_addr ),
        .rs1_gpr  (rs1_gpr  ),
        .rs2_gpr  (rs2_gpr  ),
        .ex_valid (ex_valid ),
        .ex_rd    (ex_rd    ),
        .ex_wdata (ex_wdata ),
        .wb_valid (wb_valid ),
        .wb_rd    (wb_rd    ),
        .wb_wdata (wb_wdata ),
        .rs1_data (rs1_fwd  ),
        .rs2_data (rs2_fwd  )
    );

    frv_gprs i_gprs (
        .g_clk     (g_clk    ),
        .arst_n    (arst_n   ),
        .rs1_addr  (rs1_addr ),
        .rs2_addr  (rs2_addr ),
        .rs1_data  (rs1_gpr  ),
        .rs2_data  (rs2_gpr  ),
        .gpr_wen   (gpr_wen  ),
        .gpr_rd    (gpr_rd   ),
        .gpr_wdata (gpr_wdata)
    );

    frv_execute i_execute (
        .g_clk    (g_clk     ),
        .arst_n   (arst_n    ),
        .issue    (issue_bus ),
        .result   (result_bus),
        .ex_valid (ex_valid  ),
        .ex_rd    (ex_rd     ),
        .ex_wdata (ex_wdata  )
    );

    frv_writeback i_writeback (
        .g_clk     (g_clk     ),
        .arst_n    (arst_n    ),
        .result    (result_bus),
        .trs_busy  (trs_busy  ),
        .trs_valid (trs_valid ),
        .trs_pc    (trs_pc    ),
        .trs_instr (trs_instr ),
        .trs_rd    (trs_rd    ),
        .trs_wdata (trs_wdata ),
        .wb_valid  (wb_valid  ),
        .wb_rd     (wb_rd     ),
        .wb_wdata  (wb_wdata  ),
        .gpr_wen   (gpr_wen   ),
        .gpr_rd    (gpr_rd    ),
        .gpr_wdata (gpr_wdata )
    );

endmodule

`default_nettype wire

/* frv_checker.sv */
// Trace port checker for the pipeline testbench. Holds the queue of expected
// retirements, compares every traced instruction against it and prints
// one line per test plus a closing line with the counts.
`timescale 1ns/1ps
`default_nettype none

module frv_checker (
    input  logic        g_clk,
    input  logic        arst_n,
    input  logic        in_busy,
    input  logic        trs_valid,
    input  logic        trs_busy,
    input  logic [31:0] trs_pc,
    input  logic [31:0] trs_instr,
    input  logic [4:0]  trs_rd,
    input  logic [31:0] trs_wdata,
    output int          errors,                     // All errors so far
    output int          pending                     // Issued but not yet traced
);

    logic [31:0] q_pc    [$];                       // Expected entries, program order
    logic [31:0] q_instr [$];
    logic [4:0]  q_rd    [$];
    logic [31:0] q_wdata [$];
    int          test_errors;
    int          test_retired;
    int          tests_run;
    int          tests_failed;
    int          retired;

    initial begin
        errors       = 0;
        pending      = 0;
        test_errors  = 0;
        test_retired = 0;
        tests_run    = 0;
        tests_failed = 0;
        retired      = 0;
    end

    task automatic note_error();
        errors      = errors + 1;
        test_errors = test_errors + 1;
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            note_error();
        end
    endtask

    // Called by the stimulus once an instruction is accepted
    task automatic expect_entry(input logic [31:0] pc, input logic [31:0] instr,
                                input logic [4:0] rd, input logic [31:0] wdata);
        q_pc.push_back(pc);
        q_instr.push_back(instr);
        q_rd.push_back(rd);
        q_wdata.push_back(wdata);
        pending = q_pc.size();
    endtask

    // ------------------------------------------------------------------------
    // Trace compare

    always @(posedge g_clk) begin
        if (!arst_n) begin
            compare_word("trs_valid", {31'd0, trs_valid}, 32'd0); // Quiet in reset
            compare_word("in_busy", {31'd0, in_busy}, 32'd0);
        end else if (trs_valid === 1'b1 && trs_busy === 1'b0) begin
            if (q_pc.size() == 0) begin
                $display("trace shows pc %h but no instruction was waiting to retire",
                         trs_pc);
                note_error();
            end else begin
                compare_word("trs_pc", trs_pc, q_pc.pop_front());
                compare_word("trs_instr", trs_instr, q_instr.pop_front());
                compare_word("trs_rd", {27'd0, trs_rd}, {27'd0, q_rd.pop_front()});
                compare_word("trs_wdata", trs_wdata, q_wdata.pop_front());
                pending      = q_pc.size();
                retired      = retired + 1;
                test_retired = test_retired + 1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Reporting

    task automatic report_test(input string name);
        tests_run = tests_run + 1;
        if (test_errors == 0) begin
            $display("test %0d %s: passed, %0d retired", tests_run, name, test_retired);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s: failed, %0d errors", tests_run, name, test_errors);
        end
        test_errors  = 0;
        test_retired = 0;
    endtask

    task automatic report_totals();
        $display("%0d tests, %0d failed, %0d retired, %0d errors",
                 tests_run, tests_failed, retired, errors);
    endtask

endmodule

`default_nettype wire

/* tb_frv_core_top.sv */
// Testbench for the integer pipeline. Drives instruction streams through
// the DUT, keeps a model register file and queues expected retirements
// for the trace checker.
`timescale 1ns/1ps
`default_nettype none

`include "frv_defs.svh"

module tb_frv_core_top;

    localparam logic [31:0] PC_START    = 32'h8000_0000;
    localparam int          N_LOAD      = 8;        // Test 1 loads
    localparam int          N_CHAIN     = 16;       // Test 2 ADDI chain
    localparam int          N_OPS       = 48;       // Test 2 mixed ops
    localparam int          N_FWD       = 24;
    localparam int          N_STALL     = 64;
    localparam int          N_X0        = 12;
    localparam int          TOTAL       = N_LOAD + N_CHAIN + N_OPS + N_FWD + N_STALL + N_X0;
    localparam int          CYCLE_LIMIT = 40 * TOTAL + 200;

    logic        g_clk;
    logic        arst_n;
    logic        in_valid;
    logic [31:0] in_instr;
    logic        in_busy;
    logic        trs_valid;
    logic [31:0] trs_pc;
    logic [31:0] trs_instr;
    logic [4:0]  trs_rd;
    logic [31:0] trs_wdata;
    logic        trs_busy;

    int          seed;
    int          errors;
    int          pending;
    int          cycles = 0;
    logic [31:0] model_regs [32];                   // x0 never written
    logic [31:0] next_pc;
    bit          stall_mode;                        // Random trs_busy
    bit          gap_mode;                          // Random in_valid gaps

    initial g_clk = 1'b0;
    always #20 g_clk = ~g_clk;                      // 40 ns period

    frv_core_top dut0 (
        .g_clk     (g_clk    ),
        .arst_n    (arst_n   ),
        .in_valid  (in_valid ),
        .in_instr  (in_instr ),
        .in_busy   (in_busy  ),
        .trs_valid (trs_valid),
        .trs_pc    (trs_pc   ),
        .trs_instr (trs_instr),
        .trs_rd    (trs_rd   ),
        .trs_wdata (trs_wdata),
        .trs_busy  (trs_busy )
    );

    frv_checker chk0 (
        .g_clk     (g_clk    ),
        .arst_n    (arst_n   ),
        .in_busy   (in_busy  ),
        .trs_valid (trs_valid),
        .trs_busy  (trs_busy ),
        .trs_pc    (trs_pc   ),
        .trs_instr (trs_instr),
        .trs_rd    (trs_rd   ),
        .trs_wdata (trs_wdata),
        .errors    (errors   ),
        .pending   (pending  )
    );

    // ------------------------------------------------------------------------
    // Encoding and reference model

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `FRV_OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, `FRV_OPC_OP_IMM};
    endfunction

    // k selects ADD SUB AND OR XOR SLL SRL ADDI
    function automatic logic [31:0] alu_op(input int k, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [11:0] imm);
        case (k)
            0:       return enc_r(7'd0, rs2, rs1, `FRV_F3_ADD, rd);
            1:       return enc_r(`FRV_F7_ALT, rs2, rs1, `FRV_F3_ADD, rd);
            2:       return enc_r(7'd0, rs2, rs1, `FRV_F3_AND, rd);
            3:       return enc_r(7'd0, rs2, rs1, `FRV_F3_OR, rd);
            4:       return enc_r(7'd0, rs2, rs1, `FRV_F3_XOR, rd);
            5:       return enc_r(7'd0, rs2, rs1, `FRV_F3_SLL, rd);
            6:       return enc_r(7'd0, rs2, rs1, `FRV_F3_SRL, rd);
            default: return enc_i(imm, rs1, `FRV_F3_ADD, rd);
        endcase
    endfunction

    function automatic bit supported(input logic [31:0] instr);
        if (instr[6:0] == `FRV_OPC_OP_IMM) begin
            return instr[14:12] == 3'b000;          // ADDI only
        end
        if (instr[6:0] == `FRV_OPC_OP && instr[31:25] == `FRV_F7_ALT) begin
            return instr[14:12] == 3'b000;          // SUB only
        end
        if (instr[6:0] == `FRV_OPC_OP && instr[31:25] == 7'd0) begin
            return instr[14:12] != 3'b010 && instr[14:12] != 3'b011; // No SLT, SLTU
        end
        return 1'b0;
    endfunction

    function automatic logic [31:0] expected_wdata(input logic [31:0] instr,
                                                   input logic [31:0] a,
                                                   input logic [31:0] b);
        logic [31:0] imm;
        imm = {{20{instr[31]}}, instr[31:20]};
        if (!supported(instr)) begin
            return 32'd0;                           // Retires as a NOP
        end
        if (instr[6:0] == `FRV_OPC_OP_IMM) begin
            return a + imm;
        end
        if (instr[31:25] == `FRV_F7_ALT) begin
            return a - b;
        end
        case (instr[14:12])
            3'b000:  return a + b;
            3'b001:  return a << b[4:0];
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'($random(seed));
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus tasks

    // One cycle of input, driven on the falling edge
    task automatic drive_cycle(input logic valid, input logic [31:0] instr, output bit taken);
        @(negedge g_clk);
        trs_busy = stall_mode && (($random(seed) & 1) != 0);
        in_valid = valid;
        in_instr = instr;
        #1;
        taken = valid && !in_busy;                  // Value held until the next rising edge
    endtask

    task automatic issue_instr(input logic [31:0] instr);
        logic [31:0] wd;
        logic [4:0]  rd;
        bit          taken;
        taken = 1'b0;
        if (gap_mode) begin
            while (($random(seed) & 3) == 0) begin
                drive_cycle(1'b0, $random(seed), taken);
            end
        end
        rd = supported(instr) ? instr[11:7] : 5'd0;
        wd = expected_wdata(instr, model_regs[instr[19:15]], model_regs[instr[24:20]]);
        taken = 1'b0;
        while (!taken) begin
            drive_cycle(1'b1, instr, taken);
        end
        chk0.expect_entry(next_pc, instr, rd, wd);
        if (rd != 5'd0) begin
            model_regs[rd] = wd;
        end
        next_pc = next_pc + 32'd4;
    endtask

    task automatic finish_test(input string name);
        bit taken;
        while (pending != 0) begin
            drive_cycle(1'b0, 32'd0, taken);
        end
        chk0.report_test(name);
    endtask

    // Run limit
    always @(posedge g_clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d instructions not retired",
                     cycles, pending);
            $display("Test FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Test sequence

    initial begin
        seed       = 32'h47189103;
        arst_n     = 1'b1;
        in_valid   = 1'b0;
        in_instr   = 32'd0;
        trs_busy   = 1'b0;
        stall_mode = 1'b0;
        gap_mode   = 1'b0;
        next_pc    = PC_START;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'd0;
        end
        #1 arst_n = 1'b0;
        repeat (4) @(posedge g_clk);
        @(negedge g_clk) arst_n = 1'b1;

        for (int i = 1; i <= N_LOAD; i++) begin
            issue_instr(enc_i(12'($random(seed)), 5'd0, `FRV_F3_ADD, 5'(i)));
        end
        finish_test("reset state and pc sequence");

        for (int i = N_LOAD + 1; i <= N_LOAD + N_CHAIN; i++) begin
            issue_instr(enc_i(12'($random(seed)), 5'(i - 1), `FRV_F3_ADD, 5'(i)));
        end
        for (int i = 0; i < N_OPS; i++) begin
            issue_instr(alu_op(i % 8, rand_reg(), rand_reg(), rand_reg(), 12'($random(seed))));
        end
        finish_test("all eight micro-ops");

        // Each op reads the results one and two instructions back
        for (int i = 0; i < N_FWD; i++) begin
            issue_instr(alu_op(i % 8, 5'(5 + i % 3), 5'(5 + (i + 2) % 3),
                               5'(5 + (i + 1) % 3), 12'($random(seed))));
        end
        finish_test("forwarding at distance one and two");

        stall_mode = 1'b1;
        gap_mode   = 1'b1;
        for (int i = 0; i < N_STALL; i++) begin
            issue_instr(alu_op($random(seed) & 7, rand_reg(), rand_reg(), rand_reg(),
                               12'($random(seed))));
        end
        finish_test("random back-pressure and gaps");
        stall_mode = 1'b0;
        gap_mode   = 1'b0;

        issue_instr(enc_i(12'h123, 5'd0, `FRV_F3_ADD, 5'd0));           // ADDI x0
        issue_instr(enc_r(7'd0, 5'd2, 5'd1, `FRV_F3_ADD, 5'd0));        // ADD x0
        issue_instr(enc_r(7'd0, 5'd0, 5'd0, `FRV_F3_ADD, 5'd9));        // Reads x0
        issue_instr(enc_r(7'd0, 5'd2, 5'd1, 3'b010, 5'd3));             // SLT
        issue_instr(enc_r(`FRV_F7_ALT, 5'd2, 5'd1, `FRV_F3_SRL, 5'd3)); // SRA
        issue_instr(enc_i(12'h7ff, 5'd1, 3'b010, 5'd3));                // SLTI
        issue_instr({20'habcde, 5'd3, 7'b0110111});                     // LUI
        issue_instr({25'($random(seed)), 7'b1100011});                  // Branch
        issue_instr(32'h0000_0000);
        issue_instr(32'hffff_ffff);
        issue_instr(enc_r(7'd0, 5'd0, 5'd3, `FRV_F3_ADD, 5'd11));       // x3 unchanged
        issue_instr(enc_r(7'd0, 5'd0, 5'd0, `FRV_F3_OR, 5'd12));
        finish_test("x0 writes and unsupported encodings");

        chk0.report_totals();
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* frv_core_top.f */
+incdir+.
frv_pkg.sv
frv_stage_if.sv
frv_fetch_buffer.sv
frv_decode.sv
frv_forward.sv
frv_gprs.sv
frv_execute.sv
frv_writeback.sv
frv_core_top.sv
frv_checker.sv
tb_frv_core_top.sv

/* Bender.yml */
package:
  name: frv_core

sources:
  - include_dirs:
      - .
    files:
      - frv_pkg.sv
      - frv_stage_if.sv
      - frv_fetch_buffer.sv
      - frv_decode.sv
      - frv_forward.sv
      - frv_gprs.sv
      - frv_execute.sv
      - frv_writeback.sv
      - frv_core_top.sv
  - target: test
    files:
      - frv_checker.sv
      - tb_frv_core_top.sv
